// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0] reg_idx_t;

    // ####################
    // Major opcodes
    // ####################
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // ####################
    // funct3 and funct7
    // ####################
    localparam logic [2:0] f3_jalr    = 3'b000;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;
    localparam logic [2:0] f3_blt     = 3'b100;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_addi    = 3'b000;
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_sub  = 7'b0100000;

    // Bits that take part in matching
    localparam logic [31:0] mask_op       = 32'h0000_007f;
    localparam logic [31:0] mask_op_f3    = 32'h0000_707f;
    localparam logic [31:0] mask_op_f3_f7 = 32'hfe00_707f;

    typedef enum logic [2:0] {
        fmt_none,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j
    } imm_fmt_e;

    // One instruction word in each base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage

// File: rtl/uop_pkg.sv
package uop_pkg;

    import rv_isa_pkg::*;

    localparam int TAG_BITS = 4;

    typedef enum logic [3:0] {
        alu_none,
        alu_add,
        alu_sub,
        alu_or,
        alu_and,
        alu_xor,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_none,
        wb_alu,
        wb_mem,
        wb_pc_plus4
    } wb_sel_e;

    typedef enum logic [2:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_jal,
        br_jalr
    } br_op_e;

    typedef enum logic [1:0] {
        mem_none,
        mem_load_word,
        mem_store_word
    } mem_op_e;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [TAG_BITS-1:0] tag;
        reg_idx_t            rd;
        logic [xlen-1:0]     rs1_val;
        logic [xlen-1:0]     rs2_val;
        logic [xlen-1:0]     imm;
        alu_op_e             alu_op;
        wb_sel_e             wb_sel;
        br_op_e              br_op;
        mem_op_e             mem_op;
        // AUIPC and JAL add imm to pc
        logic                use_pc;
    } uop_t;

endpackage

// File: rtl/writeback_if.sv
`timescale 1ns/1ps

interface writeback_if
    import rv_isa_pkg::*;
#(
    parameter int TAG_BITS = uop_pkg::TAG_BITS
) ();

    logic                wb_valid;
    reg_idx_t            wb_rd;
    logic [TAG_BITS-1:0] wb_tag;
    logic [xlen-1:0]     wb_data;

    modport producer (output wb_valid, wb_rd, wb_tag, wb_data);
    modport consumer (input wb_valid, wb_rd, wb_tag, wb_data);

endinterface

// File: rtl/imm_generator.sv
`timescale 1ns/1ps

module imm_generator
    import rv_isa_pkg::*;
(
    input  instr_u          instr_i,
    input  imm_fmt_e        imm_fmt_i,
    output logic [xlen-1:0] imm_o
);

    always_comb begin
        case (imm_fmt_i)
            fmt_i: begin
                imm_o = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
            end
            fmt_s: begin
                imm_o = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
            end
            // Branch offsets are always even
            fmt_b: begin
                imm_o = {{20{instr_i.b.imm_12}}, instr_i.b.imm_11, instr_i.b.imm_10_5,
                         instr_i.b.imm_4_1, 1'b0};
            end
            fmt_u: begin
                imm_o = {instr_i.u.imm, 12'b0};
            end
            fmt_j: begin
                imm_o = {{12{instr_i.j.imm_20}}, instr_i.j.imm_19_12, instr_i.j.imm_11,
                         instr_i.j.imm_10_1, 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import rv_isa_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_i,
    input  reg_idx_t        rs1_i,
    input  reg_idx_t        rs2_i,
    output logic [xlen-1:0] rs1_val_o,
    output logic [xlen-1:0] rs2_val_o,
    writeback_if.consumer   wb
);

    // x0 has no storage
    logic [xlen-1:0] regs_q [1:31];
    logic            wr_en;

    assign wr_en = wb.wb_valid && (wb.wb_rd != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            for (int r = 1; r < 32; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wb.wb_rd] <= wb.wb_data;
        end
    end

    // Write-first, a writeback in this cycle is seen at once
    always_comb begin
        rs1_val_o = '0;
        if (rs1_i != '0) begin
            rs1_val_o = (wr_en && (wb.wb_rd == rs1_i)) ? wb.wb_data : regs_q[rs1_i];
        end
    end

    always_comb begin
        rs2_val_o = '0;
        if (rs2_i != '0) begin
            rs2_val_o = (wr_en && (wb.wb_rd == rs2_i)) ? wb.wb_data : regs_q[rs2_i];
        end
    end

endmodule

// File: rtl/reg_scoreboard.sv
`timescale 1ns/1ps

module reg_scoreboard
    import rv_isa_pkg::*;
#(
    parameter int TAG_BITS = uop_pkg::TAG_BITS
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  reg_idx_t            rs1_i,
    input  reg_idx_t            rs2_i,
    input  logic                rs1_used_i,
    input  logic                rs2_used_i,
    input  logic                fetch_valid_i,
    input  logic                flush_i,
    input  logic                issue_i,
    input  reg_idx_t            issue_rd_i,
    input  logic [TAG_BITS-1:0] issue_tag_i,
    output logic                stall_o,
    writeback_if.consumer       wb
);

    logic [31:0]         busy_q;
    logic [TAG_BITS-1:0] owner_q [32];
    logic                set_busy;
    logic                clr_busy;
    logic                rs1_wait;
    logic                rs2_wait;

    // Only the newest writer of a register releases it
    assign clr_busy = wb.wb_valid && busy_q[wb.wb_rd] && (owner_q[wb.wb_rd] == wb.wb_tag);
    assign set_busy = issue_i && (issue_rd_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q <= '0;
        end else begin
            if (clr_busy) begin
                busy_q[wb.wb_rd] <= 1'b0;
            end
            // New issue wins over a release of the same register
            if (set_busy) begin
                busy_q[issue_rd_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_busy) begin
            owner_q[issue_rd_i] <= issue_tag_i;
        end
    end

    // A matching writeback in this cycle is bypassed and ends the wait
    assign rs1_wait = rs1_used_i && busy_q[rs1_i]
                      && !(wb.wb_valid && (wb.wb_rd == rs1_i) && (wb.wb_tag == owner_q[rs1_i]));
    assign rs2_wait = rs2_used_i && busy_q[rs2_i]
                      && !(wb.wb_valid && (wb.wb_rd == rs2_i) && (wb.wb_tag == owner_q[rs2_i]));

    assign stall_o = fetch_valid_i && !flush_i && (rs1_wait || rs2_wait);

    a_x0_never_busy: assert property (@(posedge clk_i) disable iff (!rst_i) !busy_q[0]);

endmodule

// File: rtl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
    import rv_isa_pkg::*, uop_pkg::*;
#(
    parameter int TAG_BITS = uop_pkg::TAG_BITS
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic [xlen-1:0]     fetch_instr_i,
    input  logic [xlen-1:0]     fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic [xlen-1:0]     rs1_val_i,
    input  logic [xlen-1:0]     rs2_val_i,
    input  logic [xlen-1:0]     imm_i,
    input  logic                stall_i,
    output reg_idx_t            rs1_o,
    output reg_idx_t            rs2_o,
    output logic                rs1_used_o,
    output logic                rs2_used_o,
    output imm_fmt_e            imm_fmt_o,
    output logic                issue_o,
    output reg_idx_t            issue_rd_o,
    output logic [TAG_BITS-1:0] issue_tag_o,
    output uop_t                uop_o,
    output logic                illegal_o
);

    // ####################
    // Instruction matching
    // ####################
    localparam int i_lui   = 0;
    localparam int i_auipc = 1;
    localparam int i_jalr  = 2;
    localparam int i_jal   = 3;
    localparam int i_beq   = 4;
    localparam int i_bne   = 5;
    localparam int i_blt   = 6;
    localparam int i_lw    = 7;
    localparam int i_sw    = 8;
    localparam int i_addi  = 9;
    localparam int i_add   = 10;
    localparam int i_sub   = 11;
    localparam int i_or    = 12;
    localparam int i_and   = 13;
    localparam int i_xor   = 14;
    localparam int n_instr = 15;

    function automatic logic [31:0] pat(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 10'b0, f3, 5'b0, op};
    endfunction

    localparam logic [31:0] instr_mask [n_instr] = '{
        mask_op, mask_op, mask_op_f3, mask_op, mask_op_f3, mask_op_f3, mask_op_f3,
        mask_op_f3, mask_op_f3, mask_op_f3, mask_op_f3_f7, mask_op_f3_f7, mask_op_f3_f7,
        mask_op_f3_f7, mask_op_f3_f7
    };

    localparam logic [31:0] instr_match [n_instr] = '{
        pat(7'b0, 3'b0, op_lui), pat(7'b0, 3'b0, op_auipc), pat(7'b0, f3_jalr, op_jalr),
        pat(7'b0, 3'b0, op_jal), pat(7'b0, f3_beq, op_branch), pat(7'b0, f3_bne, op_branch),
        pat(7'b0, f3_blt, op_branch), pat(7'b0, f3_word, op_load),
        pat(7'b0, f3_word, op_store), pat(7'b0, f3_addi, op_imm),
        pat(f7_base, f3_add_sub, op_reg), pat(f7_sub, f3_add_sub, op_reg),
        pat(f7_base, f3_or, op_reg), pat(f7_base, f3_and, op_reg), pat(f7_base, f3_xor, op_reg)
    };

    instr_u              instr;
    logic [n_instr-1:0]  hit;
    logic                offered;
    logic                accept;
    logic                has_wb;
    logic [TAG_BITS-1:0] tag_q;
    uop_t                uop_ctl;
    uop_t                uop_d;
    uop_t                uop_q;
    logic                illegal_q;

    assign instr = fetch_instr_i;

    always_comb begin
        for (int k = 0; k < n_instr; k++) begin
            hit[k] = (fetch_instr_i & instr_mask[k]) == instr_match[k];
        end
    end

    assign offered = fetch_valid_i && !flush_i;
    assign accept  = offered && !stall_i && (|hit);

    // ####################
    // Micro-op fields
    // ####################
    always_comb begin
        uop_ctl    = '0;
        rs1_used_o = 1'b0;
        rs2_used_o = 1'b0;
        imm_fmt_o  = fmt_none;
        case (1'b1)
            hit[i_lui]: begin
                imm_fmt_o      = fmt_u;
                uop_ctl.alu_op = alu_pass_b;
                uop_ctl.wb_sel = wb_alu;
            end
            hit[i_auipc]: begin
                imm_fmt_o      = fmt_u;
                uop_ctl.alu_op = alu_add;
                uop_ctl.wb_sel = wb_alu;
                uop_ctl.use_pc = 1'b1;
            end
            hit[i_jal]: begin
                imm_fmt_o      = fmt_j;
                uop_ctl.alu_op = alu_add;
                uop_ctl.wb_sel = wb_pc_plus4;
                uop_ctl.br_op  = br_jal;
                uop_ctl.use_pc = 1'b1;
            end
            hit[i_jalr]: begin
                rs1_used_o     = 1'b1;
                imm_fmt_o      = fmt_i;
                uop_ctl.alu_op = alu_add;
                uop_ctl.wb_sel = wb_pc_plus4;
                uop_ctl.br_op  = br_jalr;
            end
            hit[i_beq], hit[i_bne], hit[i_blt]: begin
                rs1_used_o    = 1'b1;
                rs2_used_o    = 1'b1;
                imm_fmt_o     = fmt_b;
                uop_ctl.br_op = hit[i_beq] ? br_beq : (hit[i_bne] ? br_bne : br_blt);
            end
            hit[i_lw]: begin
                rs1_used_o     = 1'b1;
                imm_fmt_o      = fmt_i;
                uop_ctl.alu_op = alu_add;
                uop_ctl.wb_sel = wb_mem;
                uop_ctl.mem_op = mem_load_word;
            end
            hit[i_sw]: begin
                rs1_used_o     = 1'b1;
                rs2_used_o     = 1'b1;
                imm_fmt_o      = fmt_s;
                uop_ctl.alu_op = alu_add;
                uop_ctl.mem_op = mem_store_word;
            end
            hit[i_addi]: begin
                rs1_used_o     = 1'b1;
                imm_fmt_o      = fmt_i;
                uop_ctl.alu_op = alu_add;
                uop_ctl.wb_sel = wb_alu;
            end
            hit[i_add], hit[i_sub], hit[i_or], hit[i_and], hit[i_xor]: begin
                rs1_used_o     = 1'b1;
                rs2_used_o     = 1'b1;
                uop_ctl.wb_sel = wb_alu;
                if (hit[i_sub]) begin
                    uop_ctl.alu_op = alu_sub;
                end else if (hit[i_or]) begin
                    uop_ctl.alu_op = alu_or;
                end else if (hit[i_and]) begin
                    uop_ctl.alu_op = alu_and;
                end else if (hit[i_xor]) begin
                    uop_ctl.alu_op = alu_xor;
                end else begin
                    uop_ctl.alu_op = alu_add;
                end
            end
            default: begin
                uop_ctl.alu_op = alu_none;
            end
        endcase
    end

    assign has_wb = uop_ctl.wb_sel != wb_none;

    // Operand values and bookkeeping
    always_comb begin
        uop_d         = uop_ctl;
        uop_d.valid   = accept;
        uop_d.pc      = fetch_pc_i;
        uop_d.tag     = tag_q;
        uop_d.rd      = has_wb ? instr.r.rd : '0;
        uop_d.rs1_val = rs1_used_o ? rs1_val_i : '0;
        uop_d.rs2_val = rs2_used_o ? rs2_val_i : '0;
        uop_d.imm     = imm_i;
    end

    assign rs1_o       = instr.r.rs1;
    assign rs2_o       = instr.r.rs2;
    assign issue_o     = accept && has_wb;
    assign issue_rd_o  = instr.r.rd;
    assign issue_tag_o = tag_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            uop_q.valid <= 1'b0;
            illegal_q   <= 1'b0;
            tag_q       <= '0;
        end else begin
            uop_q     <= uop_d;
            illegal_q <= offered && !stall_i && !(|hit);
            if (accept) begin
                tag_q <= tag_q + TAG_BITS'(1);
            end
        end
    end

    assign uop_o     = uop_q;
    assign illegal_o = illegal_q;

    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_i) $onehot0(hit));

endmodule

// File: rtl/decode_top.sv
`timescale 1ns/1ps

module decode_top
    import rv_isa_pkg::*, uop_pkg::*;
#(
    parameter int TAG_BITS = uop_pkg::TAG_BITS
) (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                flush_i,
    input  logic [xlen-1:0]     fetch_instr_i,
    input  logic [xlen-1:0]     fetch_pc_i,
    input  logic                fetch_valid_i,
    input  logic                wb_valid_i,
    input  reg_idx_t            wb_rd_i,
    input  logic [TAG_BITS-1:0] wb_tag_i,
    input  logic [xlen-1:0]     wb_data_i,
    output logic                stall_o,
    output logic                illegal_o,
    output uop_t                uop_o
);

    reg_idx_t            rs1;
    reg_idx_t            rs2;
    logic                rs1_used;
    logic                rs2_used;
    logic [xlen-1:0]     rs1_val;
    logic [xlen-1:0]     rs2_val;
    imm_fmt_e            imm_fmt;
    logic [xlen-1:0]     imm;
    logic                issue;
    reg_idx_t            issue_rd;
    logic [TAG_BITS-1:0] issue_tag;

    writeback_if #(.TAG_BITS(TAG_BITS)) wb_bus ();

    assign wb_bus.wb_valid = wb_valid_i;
    assign wb_bus.wb_rd    = wb_rd_i;
    assign wb_bus.wb_tag   = wb_tag_i;
    assign wb_bus.wb_data  = wb_data_i;

    instr_decoder #(.TAG_BITS(TAG_BITS)) u_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .fetch_instr_i(fetch_instr_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_valid_i(fetch_valid_i),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .imm_i        (imm),
        .stall_i      (stall_o),
        .rs1_o        (rs1),
        .rs2_o        (rs2),
        .rs1_used_o   (rs1_used),
        .rs2_used_o   (rs2_used),
        .imm_fmt_o    (imm_fmt),
        .issue_o      (issue),
        .issue_rd_o   (issue_rd),
        .issue_tag_o  (issue_tag),
        .uop_o        (uop_o),
        .illegal_o    (illegal_o)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .rs1_val_o(rs1_val),
        .rs2_val_o(rs2_val),
        .wb       (wb_bus.consumer)
    );

    reg_scoreboard #(.TAG_BITS(TAG_BITS)) u_scoreboard (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rs1_used_i   (rs1_used),
        .rs2_used_i   (rs2_used),
        .fetch_valid_i(fetch_valid_i),
        .flush_i      (flush_i),
        .issue_i      (issue),
        .issue_rd_i   (issue_rd),
        .issue_tag_i  (issue_tag),
        .stall_o      (stall_o),
        .wb           (wb_bus.consumer)
    );

    imm_generator u_imm_gen (
        .instr_i  (fetch_instr_i),
        .imm_fmt_i(imm_fmt),
        .imm_o    (imm)
    );

endmodule

// File: testbench/tb_decode_top.sv
`timescale 1ns/1ps

module tb_decode_top
    import rv_isa_pkg::*, uop_pkg::*;
();

    localparam int tag_bits     = 4;
    localparam int n_pat        = 39;
    localparam int n_field      = 22;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = n_pat + reset_cycles + 50;

    // ####################
    // Pattern columns
    // ####################
    localparam int f_group     = 0;
    localparam int f_instr     = 1;
    localparam int f_pc        = 2;
    localparam int f_valid     = 3;
    localparam int f_flush     = 4;
    localparam int f_wb_valid  = 5;
    localparam int f_wb_rd     = 6;
    localparam int f_wb_tag    = 7;
    localparam int f_wb_data   = 8;
    localparam int f_exp_stall = 9;
    localparam int f_exp_valid = 10;
    localparam int f_exp_ill   = 11;
    localparam int f_exp_tag   = 12;
    localparam int f_exp_alu   = 13;
    localparam int f_exp_wb    = 14;
    localparam int f_exp_br    = 15;
    localparam int f_exp_mem   = 16;
    localparam int f_exp_pc    = 17;
    localparam int f_exp_rd    = 18;
    localparam int f_exp_rs1   = 19;
    localparam int f_exp_rs2   = 20;
    localparam int f_exp_imm   = 21;

    logic                clk_i;
    logic                rst_i;
    logic                flush_i;
    logic [xlen-1:0]     fetch_instr_i;
    logic [xlen-1:0]     fetch_pc_i;
    logic                fetch_valid_i;
    logic                wb_valid_i;
    reg_idx_t            wb_rd_i;
    logic [tag_bits-1:0] wb_tag_i;
    logic [xlen-1:0]     wb_data_i;
    logic                stall_o;
    logic                illegal_o;
    uop_t                uop_o;

    logic [31:0] pat_mem [0:n_pat*n_field-1];
    int          group_checks [1:6];
    int          group_errors [1:6];
    int          setup_errors;
    int          cycle_count;
    int          total_checks;
    int          total_errors;

    decode_top #(.TAG_BITS(tag_bits)) u_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .fetch_instr_i(fetch_instr_i),
        .fetch_pc_i   (fetch_pc_i),
        .fetch_valid_i(fetch_valid_i),
        .wb_valid_i   (wb_valid_i),
        .wb_rd_i      (wb_rd_i),
        .wb_tag_i     (wb_tag_i),
        .wb_data_i    (wb_data_i),
        .stall_o      (stall_o),
        .illegal_o    (illegal_o),
        .uop_o        (uop_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] pattern_field(int line, int idx);
        return pat_mem[line * n_field + idx];
    endfunction

    function automatic string group_title(int grp);
        case (grp)
            1: return "register writes and R-type ops";
            2: return "immediate formats and control fields";
            3: return "stall until matching writeback";
            4: return "stale writeback keeps stall";
            5: return "flush and idle fetch";
            6: return "illegal word and x0";
            default: return "unknown group";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int grp);
        group_checks[grp]++;
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h, cycle %0d", name, got, exp, cycle_count);
            group_errors[grp]++;
        end
    endtask

    task automatic drive_idle();
        fetch_instr_i = '0;
        fetch_pc_i    = '0;
        fetch_valid_i = 1'b0;
        flush_i       = 1'b0;
        wb_valid_i    = 1'b0;
        wb_rd_i       = '0;
        wb_tag_i      = '0;
        wb_data_i     = '0;
    endtask

    task automatic drive_pattern(input int line);
        fetch_instr_i = pattern_field(line, f_instr);
        fetch_pc_i    = pattern_field(line, f_pc);
        fetch_valid_i = pattern_field(line, f_valid) != 0;
        flush_i       = pattern_field(line, f_flush) != 0;
        wb_valid_i    = pattern_field(line, f_wb_valid) != 0;
        wb_rd_i       = 5'(pattern_field(line, f_wb_rd));
        wb_tag_i      = tag_bits'(pattern_field(line, f_wb_tag));
        wb_data_i     = pattern_field(line, f_wb_data);
    endtask

    // Registered outputs, one cycle after the line was driven
    task automatic check_outputs(input int line);
        int grp;
        grp = pattern_field(line, f_group);
        check_value("uop_o.valid", 32'(uop_o.valid), pattern_field(line, f_exp_valid), grp);
        check_value("illegal_o", 32'(illegal_o), pattern_field(line, f_exp_ill), grp);
        if (pattern_field(line, f_exp_valid) != 0) begin
            check_value("uop_o.pc", uop_o.pc, pattern_field(line, f_pc), grp);
            check_value("uop_o.tag", 32'(uop_o.tag), pattern_field(line, f_exp_tag), grp);
            check_value("uop_o.alu_op", 32'(uop_o.alu_op), pattern_field(line, f_exp_alu), grp);
            check_value("uop_o.wb_sel", 32'(uop_o.wb_sel), pattern_field(line, f_exp_wb), grp);
            check_value("uop_o.br_op", 32'(uop_o.br_op), pattern_field(line, f_exp_br), grp);
            check_value("uop_o.mem_op", 32'(uop_o.mem_op), pattern_field(line, f_exp_mem), grp);
            check_value("uop_o.use_pc", 32'(uop_o.use_pc), pattern_field(line, f_exp_pc), grp);
            check_value("uop_o.rd", 32'(uop_o.rd), pattern_field(line, f_exp_rd), grp);
            check_value("uop_o.rs1_val", uop_o.rs1_val, pattern_field(line, f_exp_rs1), grp);
            check_value("uop_o.rs2_val", uop_o.rs2_val, pattern_field(line, f_exp_rs2), grp);
            check_value("uop_o.imm", uop_o.imm, pattern_field(line, f_exp_imm), grp);
        end
    endtask

    task automatic report_group(input int grp);
        string status;
        status = (group_errors[grp] == 0) ? "ok" : "failed";
        $display("Group %0d, %s: %0d checks, %0d errors, %s", grp, group_title(grp),
                 group_checks[grp], group_errors[grp], status);
    endtask

    initial begin
        int grp;
        setup_errors = 0;
        cycle_count  = 0;
        total_checks = 0;
        total_errors = 0;
        for (int g = 1; g <= 6; g++) begin
            group_checks[g] = 0;
            group_errors[g] = 0;
        end
        rst_i = 1'b0;
        drive_idle();
        $readmemh("testbench/decode_patterns.mem", pat_mem);
        grp = pattern_field(n_pat - 1, f_group);
        assert (grp >= 1 && grp <= 6) else begin
            $display("Pattern file did not load completely, last line has no group number");
            setup_errors++;
        end

        repeat (reset_cycles) @(posedge clk_i);
        #1;
        rst_i = 1'b1;
        check_value("uop_o.valid", 32'(uop_o.valid), 32'h0, 1);
        check_value("illegal_o", 32'(illegal_o), 32'h0, 1);
        check_value("stall_o", 32'(stall_o), 32'h0, 1);

        // ####################
        // Pattern loop
        // ####################
        for (int n = 0; n < n_pat; n++) begin
            drive_pattern(n);
            #4;
            check_value("stall_o", 32'(stall_o), pattern_field(n, f_exp_stall),
                        pattern_field(n, f_group));
            @(posedge clk_i);
            #1;
            check_outputs(n);
            if (n == n_pat - 1 || pattern_field(n + 1, f_group) != pattern_field(n, f_group)) begin
                report_group(pattern_field(n, f_group));
            end
        end
        drive_idle();

        for (int g = 1; g <= 6; g++) begin
            total_checks += group_checks[g];
            total_errors += group_errors[g];
        end
        $display("Checks: %0d, errors: %0d, setup errors: %0d", total_checks, total_errors,
                 setup_errors);
        if (total_errors == 0 && setup_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: testbench/decode_patterns.mem
// grp instr pc valid flush wb_valid wb_rd wb_tag wb_data | exp: stall valid illegal tag
// alu_op wb_sel br_op mem_op use_pc rd rs1_val rs2_val imm (uop fields seen one cycle later)
//
// Group 1: load x1..x4 by writeback, then ADD SUB OR AND XOR
1 00000000 000 0 0 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
1 00000000 000 0 0 1 01 0 12345678 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
1 00000000 000 0 0 1 02 0 0f0f0f0f 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
1 00000000 000 0 0 1 03 0 00000005 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
1 00000000 000 0 0 1 04 0 fffffff0 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
1 002082b3 100 1 0 0 00 0 00000000 0 1 0 0 1 1 0 0 0 05 12345678 0f0f0f0f 00000000
1 40308333 104 1 0 0 00 0 00000000 0 1 0 1 2 1 0 0 0 06 12345678 00000005 00000000
1 004163b3 108 1 0 0 00 0 00000000 0 1 0 2 3 1 0 0 0 07 0f0f0f0f fffffff0 00000000
1 0040f433 10c 1 0 0 00 0 00000000 0 1 0 3 4 1 0 0 0 08 12345678 fffffff0 00000000
1 003144b3 110 1 0 0 00 0 00000000 0 1 0 4 5 1 0 0 0 09 0f0f0f0f 00000005 00000000
// Group 2: ADDI LUI AUIPC LW SW BEQ BNE BLT JAL JALR
2 ffb08513 114 1 0 0 00 0 00000000 0 1 0 5 1 1 0 0 0 0a 12345678 00000000 fffffffb
2 abcde5b7 118 1 0 0 00 0 00000000 0 1 0 6 6 1 0 0 0 0b 00000000 00000000 abcde000
2 00001617 11c 1 0 0 00 0 00000000 0 1 0 7 1 1 0 0 1 0c 00000000 00000000 00001000
2 00812683 120 1 0 0 00 0 00000000 0 1 0 8 1 2 0 1 0 0d 0f0f0f0f 00000000 00000008
2 fe30ae23 124 1 0 0 00 0 00000000 0 1 0 9 1 0 0 2 0 00 12345678 00000005 fffffffc
2 00208863 128 1 0 0 00 0 00000000 0 1 0 a 0 0 1 0 0 00 12345678 0f0f0f0f 00000010
2 fe419ce3 12c 1 0 0 00 0 00000000 0 1 0 b 0 0 2 0 0 00 00000005 fffffff0 fffffff8
2 001140e3 130 1 0 0 00 0 00000000 0 1 0 c 0 0 3 0 0 00 0f0f0f0f 12345678 00000800
2 0071076f 134 1 0 0 00 0 00000000 0 1 0 d 1 3 4 0 1 0e 00000000 00000000 00010806
2 fff187e7 138 1 0 0 00 0 00000000 0 1 0 e 1 3 5 0 0 0f 00000005 00000000 ffffffff
// Group 3: ADD reads x16 from the ADDI just issued, released by its writeback
3 00108813 13c 1 0 0 00 0 00000000 0 1 0 f 1 1 0 0 0 10 12345678 00000000 00000001
3 002808b3 140 1 0 0 00 0 00000000 1 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
3 002808b3 140 1 0 0 00 0 00000000 1 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
3 002808b3 140 1 0 1 10 f 12345679 0 1 0 0 1 1 0 0 0 11 12345679 0f0f0f0f 00000000
// Group 4: two writers of x18, the older writeback does not release
4 00700913 144 1 0 0 00 0 00000000 0 1 0 1 1 1 0 0 0 12 00000000 00000000 00000007
4 00900913 148 1 0 0 00 0 00000000 0 1 0 2 1 1 0 0 0 12 00000000 00000000 00000009
4 001969b3 14c 1 0 1 12 1 dead0001 1 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
4 001969b3 14c 1 0 0 00 0 00000000 1 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
4 001969b3 14c 1 0 1 12 2 000000a5 0 1 0 3 3 1 0 0 0 13 000000a5 12345678 00000000
// Group 5: flush and fetch_valid low, tag holds
5 00208a13 150 1 1 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
5 00098ab3 150 0 0 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
5 00098ab3 150 1 1 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
5 00208a13 150 1 0 0 00 0 00000000 0 1 0 4 1 1 0 0 0 14 12345678 00000000 00000002
// Group 6: unknown words, then a write to x0 that must not show
6 ffffffff 154 1 0 0 00 0 00000000 0 0 1 0 0 0 0 0 0 00 00000000 00000000 00000000
6 02208133 154 1 0 0 00 0 00000000 0 0 1 0 0 0 0 0 0 00 00000000 00000000 00000000
6 00000000 154 0 0 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000
6 00000b33 154 1 0 1 00 0 ffffffff 0 1 0 5 1 1 0 0 0 16 00000000 00000000 00000000
6 00000b93 158 1 0 0 00 0 00000000 0 1 0 6 1 1 0 0 0 17 00000000 00000000 00000000
6 00000000 000 0 0 0 00 0 00000000 0 0 0 0 0 0 0 0 0 00 00000000 00000000 00000000

// File: files.f
rtl/rv_isa_pkg.sv
rtl/uop_pkg.sv
rtl/writeback_if.sv
rtl/imm_generator.sv
rtl/reg_file.sv
rtl/reg_scoreboard.sv
rtl/instr_decoder.sv
rtl/decode_top.sv
testbench/tb_decode_top.sv
